/* Makefile */
VERILATOR ?= verilator
TOP       ?= cpu_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Done: no errors

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(wildcard logic/*.sv logic/*.svh dv/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* dv/cpu_props.sv */
`include "cpu_cfg.svh"

module cpu_props
    import cpu_pkg::*;
(
    input logic     clk,
    input logic     rst_n,
    input logic     inst_sram_en,
    input word_t    inst_sram_addr,
    input logic     data_sram_en,
    input byte_en_t data_sram_wen,
    input byte_en_t debug_wb_rf_wen,
    input logic     fs_to_ds_valid,
    input logic     ds_to_es_valid,
    input logic     es_to_ms_valid,
    input logic     ms_to_ws_valid,
    input logic     ds_allowin,
    input logic     load_stall,
    input word_t    fs_pc
);

    logic quiet;

    assign quiet = !inst_sram_en && !data_sram_en && data_sram_wen == '0 &&
                   debug_wb_rf_wen == '0 && !fs_to_ds_valid && !ds_to_es_valid &&
                   !es_to_ms_valid && !ms_to_ws_valid;

    reset_quiet: assert property (@(posedge clk) !rst_n |-> quiet)
        else $error("outputs active during reset");

    // first cycle after release stays quiet, then the reset PC goes out
    first_fetch: assert property (@(posedge clk) $rose(rst_n) |-> quiet ##1
                                  (inst_sram_en && inst_sram_addr == `CPU_RESET_PC))
        else $error("first fetch wrong after reset");

    trace_wen: assert property (@(posedge clk) disable iff (!rst_n)
                                debug_wb_rf_wen == 4'h0 || debug_wb_rf_wen == 4'hf)
        else $error("trace write enable neither 0 nor f");

    store_en: assert property (@(posedge clk) disable iff (!rst_n)
                               data_sram_wen != '0 |-> data_sram_en)
        else $error("data write enable without data enable");

    stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
                                 (load_stall && fs_to_ds_valid) |->
                                 (!ds_allowin && inst_sram_addr == fs_pc && !ds_to_es_valid)
                                 ##1 $stable(fs_pc))
        else $error("fetch address moved during a decode stall");

endmodule

/* dv/cpu_tb.sv */
`include "cpu_cfg.svh"

module cpu_tb;
    import cpu_pkg::*;

    localparam int CLK_PERIOD = 40;
    // program lengths include the closing marker and loop
    localparam int LEN_ALU    = 22;
    localparam int LEN_LOAD   = 20;
    localparam int LEN_BRANCH = 26;
    localparam int LEN_ZERO   = 14;
    localparam int TOTAL_INSTS = LEN_ALU + LEN_LOAD + LEN_BRANCH + LEN_ZERO;

    localparam logic [5:0] OP_R     = 6'h00;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;
    localparam logic [5:0] FN_ADDU  = 6'h21;
    localparam logic [5:0] FN_SUBU  = 6'h23;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_SLT   = 6'h2a;

    logic     clk;
    logic     rst_n;
    logic     inst_sram_en;
    byte_en_t inst_sram_wen;
    word_t    inst_sram_addr;
    word_t    inst_sram_wdata;
    word_t    inst_sram_rdata;
    logic     data_sram_en;
    byte_en_t data_sram_wen;
    word_t    data_sram_addr;
    word_t    data_sram_wdata;
    word_t    data_sram_rdata;
    word_t    debug_wb_pc;
    byte_en_t debug_wb_rf_wen;
    reg_idx_t debug_wb_rf_wnum;
    word_t    debug_wb_rf_wdata;

    word_t imem [256];
    word_t dmem [64];
    // reference model state
    word_t mregs [`CPU_NUM_REGS];
    word_t mdmem [64];
    word_t mpc;
    word_t marker_pc;
    word_t end_pc;
    int    n_prog;
    logic  done;
    logic  [31:0] lfsr;
    int    errors;
    int    tests_run;

    cpu_top cpu_top_i (.*);

    bind cpu_top cpu_props cpu_props_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // synchronous SRAMs return read data one cycle after the request
    always @(posedge clk) begin
        if (inst_sram_en) begin
            inst_sram_rdata <= imem[inst_sram_addr[9:2]];
        end
        if (data_sram_en) begin
            if (data_sram_wen != '0) begin
                dmem[data_sram_addr[7:2]] <= data_sram_wdata;
            end
            data_sram_rdata <= dmem[data_sram_addr[7:2]];
        end
    end

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha300_0000) : (lfsr >> 1);
        end
        return r;
    endfunction

    // one of r0..r7
    function automatic reg_idx_t rand_reg();
        return reg_idx_t'(rand_bits(3));
    endfunction

    function automatic word_t r_type(logic [5:0] fn, reg_idx_t rs, reg_idx_t rt, reg_idx_t rd);
        return {OP_R, rs, rt, rd, 5'h00, fn};
    endfunction

    function automatic word_t i_type(logic [5:0] op, reg_idx_t rs, reg_idx_t rt,
                                     logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic emit(word_t inst);
        imem[n_prog] = inst;
        n_prog++;
    endtask

    // marker writes r0 and then a branch-to-self parks fetch
    task automatic close_program();
        marker_pc = n_prog * 4;
        emit(i_type(OP_ADDIU, 5'd0, 5'd0, 16'h00ee));
        end_pc = n_prog * 4;
        emit(i_type(OP_BEQ, 5'd0, 5'd0, 16'hffff));
    endtask

    task automatic start_program();
        n_prog = 0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            dmem[i]  = 32'h5a5a_0000 ^ ~(i * 32'h0401_0004);
            mdmem[i] = dmem[i];
        end
    endtask

    // executes one instruction by the ISA and reports a register write if any
    task automatic model_step(output logic wrote, output reg_idx_t wn, output word_t wv);
        word_t inst;
        word_t a;
        word_t b;
        word_t sx;
        word_t addr;
        word_t npc;
        inst  = imem[mpc[9:2]];
        a     = mregs[inst[25:21]];
        b     = mregs[inst[20:16]];
        sx    = {{16{inst[15]}}, inst[15:0]};
        addr  = a + sx;
        npc   = mpc + 4;
        wrote = 1'b1;
        wn    = inst[20:16];
        wv    = '0;
        case (inst[31:26])
            OP_R: begin
                wn = inst[15:11];
                case (inst[5:0])
                    FN_ADDU: wv = a + b;
                    FN_SUBU: wv = a - b;
                    FN_AND:  wv = a & b;
                    FN_OR:   wv = a | b;
                    FN_SLT:  wv = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: wrote = 1'b0;
                endcase
            end
            OP_ADDIU: wv = addr;
            OP_LUI:   wv = {inst[15:0], 16'h0000};
            OP_LW:    wv = mdmem[addr[7:2]];
            OP_SW: begin
                mdmem[addr[7:2]] = b;
                wrote = 1'b0;
            end
            OP_BEQ: begin
                wrote = 1'b0;
                if (a == b) npc = mpc + 4 + {sx[29:0], 2'b00};
            end
            OP_BNE: begin
                wrote = 1'b0;
                if (a != b) npc = mpc + 4 + {sx[29:0], 2'b00};
            end
            default: wrote = 1'b0;
        endcase
        if (wrote && wn != '0) begin
            mregs[wn] = wv;
        end
        mpc = npc;
    endtask

    task automatic check_retire();
        logic     wrote;
        reg_idx_t wn;
        word_t    wv;
        word_t    pc;
        wrote = 1'b0;
        pc    = mpc;
        // stores and branches leave no trace entry
        while (!wrote && mpc != end_pc) begin
            pc = mpc;
            model_step(wrote, wn, wv);
        end
        if (!wrote) begin
            $display("trace shows a retirement after the program ended, at %0t", $time);
            errors++;
        end else begin
            assert (debug_wb_pc == pc) else begin
                $display("MISMATCH %0t debug_wb_pc expected %h actual %h",
                         $time, pc, debug_wb_pc);
                errors++;
            end
            assert (debug_wb_rf_wnum == wn) else begin
                $display("MISMATCH %0t debug_wb_rf_wnum expected %0d actual %0d",
                         $time, wn, debug_wb_rf_wnum);
                errors++;
            end
            assert (debug_wb_rf_wdata == wv) else begin
                $display("MISMATCH %0t debug_wb_rf_wdata expected %h actual %h",
                         $time, wv, debug_wb_rf_wdata);
                errors++;
            end
            if (pc == marker_pc) done = 1'b1;
        end
    endtask

    always @(negedge clk) begin
        if (rst_n && debug_wb_rf_wen == 4'hf) begin
            check_retire();
        end
        // the instruction port never writes
        assert (inst_sram_wen == '0) else begin
            $display("MISMATCH %0t inst_sram_wen expected %h actual %h",
                     $time, 4'h0, inst_sram_wen);
            errors++;
        end
        assert (inst_sram_wdata == '0) else begin
            $display("MISMATCH %0t inst_sram_wdata expected %h actual %h",
                     $time, 32'h0, inst_sram_wdata);
            errors++;
        end
    end

    task automatic run_program(string name);
        int errors_before;
        errors_before = errors;
        for (int i = 0; i < `CPU_NUM_REGS; i++) begin
            mregs[i] = '0;
        end
        mpc  = `CPU_RESET_PC;
        done = 1'b0;
        @(negedge clk);
        rst_n = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        wait (done);
        for (int i = 0; i < 64; i++) begin
            assert (dmem[i] == mdmem[i]) else begin
                $display("MISMATCH %0t dmem[%0d] expected %h actual %h",
                         $time, i, mdmem[i], dmem[i]);
                errors++;
            end
        end
        tests_run++;
        $display("test %s: %0d errors", name, errors - errors_before);
    endtask

    initial begin
        rst_n           = 1'b0;
        inst_sram_rdata = '0;
        data_sram_rdata = '0;
        lfsr            = 32'h731b;
        errors          = 0;
        tests_run       = 0;
        done            = 1'b0;

        // dependent ALU chain over r0..r7
        start_program();
        for (int i = 0; i < LEN_ALU - 2; i++) begin
            case (rand_bits(3))
                0: emit(r_type(FN_ADDU, rand_reg(), rand_reg(), rand_reg()));
                1: emit(r_type(FN_SUBU, rand_reg(), rand_reg(), rand_reg()));
                2: emit(r_type(FN_AND, rand_reg(), rand_reg(), rand_reg()));
                3: emit(r_type(FN_OR, rand_reg(), rand_reg(), rand_reg()));
                4: emit(r_type(FN_SLT, rand_reg(), rand_reg(), rand_reg()));
                5: emit(i_type(OP_LUI, 5'd0, rand_reg(), 16'(rand_bits(16))));
                default: emit(i_type(OP_ADDIU, rand_reg(), rand_reg(), 16'(rand_bits(16))));
            endcase
        end
        close_program();
        run_program("alu_chain");

        // lw, an addu that uses the loaded value, then a store of the sum
        start_program();
        for (int i = 0; i < (LEN_LOAD - 2) / 3; i++) begin
            reg_idx_t ld_dest;
            ld_dest = 5'd1 + reg_idx_t'(rand_bits(2));
            emit(i_type(OP_LW, 5'd0, ld_dest, 16'(rand_bits(6)) << 2));
            emit(r_type(FN_ADDU, ld_dest, 5'd1 + reg_idx_t'(rand_bits(2)), 5'd5));
            emit(i_type(OP_SW, 5'd0, 5'd5, 16'(rand_bits(6)) << 2));
        end
        close_program();
        run_program("load_use");

        // a taken branch skips the addiu behind it
        start_program();
        for (int i = 0; i < (LEN_BRANCH - 2) / 4; i++) begin
            logic [15:0] br_val;
            br_val = 16'(rand_bits(2));
            emit(i_type(OP_ADDIU, 5'd0, 5'd1, br_val));
            // beq and bne each meet equal and unequal operands
            emit(i_type(OP_ADDIU, 5'd0, 5'd2, i[1] ? br_val : br_val ^ 16'h0001));
            emit(i_type(i[0] ? OP_BNE : OP_BEQ, 5'd1, 5'd2, 16'd1));
            emit(i_type(OP_ADDIU, 5'd3, 5'd3, 16'd1));
        end
        close_program();
        run_program("branches");

        // r0 writes must stay invisible to later readers
        start_program();
        for (int i = 0; i < (LEN_ZERO - 2) / 3; i++) begin
            emit(i_type(OP_ADDIU, 5'd0, 5'd0, 16'(rand_bits(16)) | 16'h0001));
            emit(r_type(FN_ADDU, 5'd0, 5'd0, 5'd4));
            emit(r_type(FN_OR, 5'd0, 5'd4, 5'd6));
        end
        close_program();
        run_program("reg_zero");

        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #((TOTAL_INSTS * 8 + 4 * 16) * CLK_PERIOD);
        $display("watchdog expired before all tests finished");
        $display("Done: errors found");
        $finish;
    end

endmodule

/* logic/cpu_cfg.svh */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// first fetch address once reset is released
`define CPU_RESET_PC 32'h0000_0000

// architectural registers, r0 included
`define CPU_NUM_REGS 32

// data and address word
`define CPU_WORD_W 32

// register number field
`define CPU_REG_IDX_W 5

// one enable bit per byte lane of a word
`define CPU_BE_W 4

`endif

/* logic/cpu_pkg.sv */
`include "cpu_cfg.svh"

package cpu_pkg;

    typedef logic [`CPU_WORD_W-1:0] word_t;
    typedef logic [`CPU_REG_IDX_W-1:0] reg_idx_t;
    typedef logic [`CPU_BE_W-1:0] byte_en_t;

    // decode to execute
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI
    } alu_op_e;

    // operand source, youngest writer wins
    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_EX,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

    typedef enum logic {
        DS_EMPTY,
        DS_FULL
    } ds_state_e;

endpackage

/* logic/cpu_top.sv */
module cpu_top
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    output logic     inst_sram_en,
    output byte_en_t inst_sram_wen,
    output word_t    inst_sram_addr,
    output word_t    inst_sram_wdata,
    input  word_t    inst_sram_rdata,
    output logic     data_sram_en,
    output byte_en_t data_sram_wen,
    output word_t    data_sram_addr,
    output word_t    data_sram_wdata,
    input  word_t    data_sram_rdata,
    output word_t    debug_wb_pc,
    output byte_en_t debug_wb_rf_wen,
    output reg_idx_t debug_wb_rf_wnum,
    output word_t    debug_wb_rf_wdata
);

    // stage handshake
    logic fs_to_ds_valid;
    logic ds_to_es_valid;
    logic es_to_ms_valid;
    logic ms_to_ws_valid;
    logic ds_allowin;
    logic es_allowin;
    logic ms_allowin;
    logic ws_allowin;

    // payload
    word_t    fs_pc;
    word_t    fs_inst;
    word_t    ds_pc;
    word_t    ds_src_a;
    word_t    ds_src_b;
    word_t    ds_store_data;
    reg_idx_t ds_dest;
    alu_op_e  ds_alu_op;
    logic     ds_gr_we;
    logic     ds_load;
    logic     ds_store;
    word_t    es_pc;
    word_t    es_result;
    reg_idx_t es_dest;
    logic     es_gr_we;
    logic     es_load;
    word_t    ms_pc;
    word_t    ms_result;
    reg_idx_t ms_dest;
    logic     ms_gr_we;

    // redirect, write-back and hazard control
    logic     br_taken;
    word_t    br_target;
    logic     rf_we;
    reg_idx_t rf_waddr;
    word_t    rf_wdata;
    reg_idx_t ds_rs;
    reg_idx_t ds_rt;
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;
    logic     load_stall;

    fetch_stage fetch_stage_i (.*);

    decode_stage decode_stage_i (.*);

    exec_stage exec_stage_i (.*);

    mem_stage mem_stage_i (.*);

    wb_stage wb_stage_i (.*);

    // stage outputs stand in for the stage valids, write-back port for its payload
    hazard_unit hazard_unit_i (
        .es_valid (es_to_ms_valid),
        .ms_valid (ms_to_ws_valid),
        .ws_valid (rf_we),
        .ws_dest  (rf_waddr),
        .ws_gr_we (rf_we),
        .*
    );

endmodule

/* logic/decode_stage.sv */
module decode_stage
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     fs_to_ds_valid,
    input  word_t    fs_pc,
    input  word_t    fs_inst,
    output logic     ds_allowin,
    input  logic     es_allowin,
    output logic     ds_to_es_valid,
    output word_t    ds_pc,
    output word_t    ds_src_a,
    output word_t    ds_src_b,
    output word_t    ds_store_data,
    output reg_idx_t ds_dest,
    output alu_op_e  ds_alu_op,
    output logic     ds_gr_we,
    output logic     ds_load,
    output logic     ds_store,
    output reg_idx_t ds_rs,
    output reg_idx_t ds_rt,
    input  fwd_sel_e fwd_a,
    input  fwd_sel_e fwd_b,
    input  logic     load_stall,
    input  word_t    es_result,
    input  word_t    ms_result,
    input  logic     rf_we,
    input  reg_idx_t rf_waddr,
    input  word_t    rf_wdata,
    output logic     br_taken,
    output word_t    br_target
);

    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;
    localparam logic [5:0] FN_ADDU    = 6'h21;
    localparam logic [5:0] FN_SUBU    = 6'h23;
    localparam logic [5:0] FN_AND     = 6'h24;
    localparam logic [5:0] FN_OR      = 6'h25;
    localparam logic [5:0] FN_SLT     = 6'h2a;

    ds_state_e  state;
    word_t      inst;
    logic       ds_valid;
    logic       ds_ready_go;
    logic [5:0] opcode;
    logic [5:0] funct;
    logic       is_alu_r;
    logic       is_addiu;
    logic       is_lui;
    logic       is_beq;
    logic       is_bne;
    word_t      imm_sext;
    word_t      rf_rdata1;
    word_t      rf_rdata2;
    word_t      val_a;
    word_t      val_b;

    function automatic word_t pick(fwd_sel_e sel, word_t rf_val, word_t ex_val,
                                   word_t mem_val, word_t wb_val);
        case (sel)
            FWD_EX:  pick = ex_val;
            FWD_MEM: pick = mem_val;
            FWD_WB:  pick = wb_val;
            default: pick = rf_val;
        endcase
    endfunction

    assign ds_valid       = (state == DS_FULL);
    assign ds_ready_go    = !load_stall;
    assign ds_allowin     = !ds_valid || (ds_ready_go && es_allowin);
    // a load-use stall sends a bubble and keeps the instruction here
    assign ds_to_es_valid = ds_valid && ds_ready_go;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= DS_EMPTY;
        end else if (ds_allowin) begin
            state <= fs_to_ds_valid ? DS_FULL : DS_EMPTY;
        end
    end

    always_ff @(posedge clk) begin
        if (ds_allowin && fs_to_ds_valid) begin
            ds_pc <= fs_pc;
            inst  <= fs_inst;
        end
    end

    assign opcode   = inst[31:26];
    assign funct    = inst[5:0];
    assign imm_sext = {{16{inst[15]}}, inst[15:0]};
    assign is_alu_r = (opcode == OP_SPECIAL) &&
                      (funct == FN_ADDU || funct == FN_SUBU || funct == FN_AND ||
                       funct == FN_OR || funct == FN_SLT);
    assign is_addiu = (opcode == OP_ADDIU);
    assign is_lui   = (opcode == OP_LUI);
    assign is_beq   = (opcode == OP_BEQ);
    assign is_bne   = (opcode == OP_BNE);
    assign ds_load  = (opcode == OP_LW);
    assign ds_store = (opcode == OP_SW);
    assign ds_gr_we = is_alu_r || is_addiu || is_lui || ds_load;

    // unused sources read as r0 so they never hit a hazard
    assign ds_rs   = (is_lui || !(ds_gr_we || ds_store || is_beq || is_bne)) ? '0 : inst[25:21];
    assign ds_rt   = (is_alu_r || ds_store || is_beq || is_bne) ? inst[20:16] : '0;
    assign ds_dest = !ds_gr_we ? '0 : (is_alu_r ? inst[15:11] : inst[20:16]);

    always_comb begin
        ds_alu_op = ALU_ADD;
        if (is_lui) begin
            ds_alu_op = ALU_LUI;
        end else if (is_alu_r) begin
            case (funct)
                FN_SUBU: ds_alu_op = ALU_SUB;
                FN_AND:  ds_alu_op = ALU_AND;
                FN_OR:   ds_alu_op = ALU_OR;
                FN_SLT:  ds_alu_op = ALU_SLT;
                default: ds_alu_op = ALU_ADD;
            endcase
        end
    end

    reg_file reg_file_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr1 (ds_rs),
        .raddr2 (ds_rt),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    assign val_a = pick(fwd_a, rf_rdata1, es_result, ms_result, rf_wdata);
    assign val_b = pick(fwd_b, rf_rdata2, es_result, ms_result, rf_wdata);

    assign ds_src_a      = val_a;
    assign ds_src_b      = is_alu_r ? val_b : imm_sext;
    assign ds_store_data = val_b;

    // resolved here and fires only as the branch moves on
    assign br_target = ds_pc + 32'd4 + {imm_sext[29:0], 2'b00};
    assign br_taken  = ds_valid && ds_ready_go && es_allowin &&
                       ((is_beq && val_a == val_b) || (is_bne && val_a != val_b));

endmodule

/* logic/exec_stage.sv */
module exec_stage
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     ds_to_es_valid,
    input  word_t    ds_pc,
    input  word_t    ds_src_a,
    input  word_t    ds_src_b,
    input  word_t    ds_store_data,
    input  reg_idx_t ds_dest,
    input  alu_op_e  ds_alu_op,
    input  logic     ds_gr_we,
    input  logic     ds_load,
    input  logic     ds_store,
    output logic     es_allowin,
    input  logic     ms_allowin,
    output logic     es_to_ms_valid,
    output word_t    es_pc,
    output word_t    es_result,
    output reg_idx_t es_dest,
    output logic     es_gr_we,
    output logic     es_load,
    output logic     data_sram_en,
    output byte_en_t data_sram_wen,
    output word_t    data_sram_addr,
    output word_t    data_sram_wdata
);

    logic    es_valid;
    logic    es_store;
    logic    mem_go;
    word_t   src_a;
    word_t   src_b;
    word_t   store_data;
    word_t   sum;
    alu_op_e alu_op;

    // single-cycle ALU, the item is always ready to go
    assign es_allowin     = !es_valid || ms_allowin;
    assign es_to_ms_valid = es_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_to_es_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es_allowin && ds_to_es_valid) begin
            es_pc      <= ds_pc;
            src_a      <= ds_src_a;
            src_b      <= ds_src_b;
            store_data <= ds_store_data;
            es_dest    <= ds_dest;
            alu_op     <= ds_alu_op;
            es_gr_we   <= ds_gr_we;
            es_load    <= ds_load;
            es_store   <= ds_store;
        end
    end

    assign sum = src_a + src_b;

    always_comb begin
        case (alu_op)
            ALU_SUB: es_result = src_a - src_b;
            ALU_AND: es_result = src_a & src_b;
            ALU_OR:  es_result = src_a | src_b;
            ALU_SLT: es_result = word_t'($signed(src_a) < $signed(src_b));
            ALU_LUI: es_result = {src_b[15:0], 16'h0000};
            default: es_result = sum;
        endcase
    end

    // request only as the access moves into memory
    assign mem_go          = es_valid && ms_allowin;
    assign data_sram_en    = mem_go && (es_load || es_store);
    assign data_sram_wen   = (mem_go && es_store) ? '1 : '0;
    assign data_sram_addr  = sum;
    assign data_sram_wdata = store_data;

endmodule

/* logic/fetch_stage.sv */
`include "cpu_cfg.svh"

module fetch_stage
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     ds_allowin,
    input  logic     br_taken,
    input  word_t    br_target,
    output logic     fs_to_ds_valid,
    output word_t    fs_pc,
    output word_t    fs_inst,
    output logic     inst_sram_en,
    output byte_en_t inst_sram_wen,
    output word_t    inst_sram_addr,
    output word_t    inst_sram_wdata,
    input  word_t    inst_sram_rdata
);

    logic  started;
    logic  fs_valid;
    logic  fs_allowin;
    word_t next_pc;

    // first request goes out one cycle after reset release
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            started <= 1'b0;
        end else begin
            started <= 1'b1;
        end
    end

    assign fs_allowin = !fs_valid || ds_allowin;
    assign next_pc    = br_taken ? br_target : fs_pc + 32'd4;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fs_valid <= 1'b0;
            fs_pc    <= `CPU_RESET_PC - 32'd4;
        end else if (fs_allowin && started) begin
            fs_valid <= 1'b1;
            fs_pc    <= next_pc;
        end
    end

    // wrong-path slot behind a taken branch never reaches decode
    assign fs_to_ds_valid = fs_valid && !br_taken;
    assign fs_inst        = inst_sram_rdata;

    // while held, re-read the same word so rdata stays put
    assign inst_sram_en    = started;
    assign inst_sram_addr  = fs_allowin ? next_pc : fs_pc;
    assign inst_sram_wen   = '0;
    assign inst_sram_wdata = '0;

endmodule

/* logic/hazard_unit.sv */
module hazard_unit
    import cpu_pkg::*;
(
    input  reg_idx_t ds_rs,
    input  reg_idx_t ds_rt,
    input  logic     es_valid,
    input  reg_idx_t es_dest,
    input  logic     es_gr_we,
    input  logic     es_load,
    input  logic     ms_valid,
    input  reg_idx_t ms_dest,
    input  logic     ms_gr_we,
    input  logic     ws_valid,
    input  reg_idx_t ws_dest,
    input  logic     ws_gr_we,
    output fwd_sel_e fwd_a,
    output fwd_sel_e fwd_b,
    output logic     load_stall
);

    logic es_hit_a;
    logic es_hit_b;
    logic ms_hit_a;
    logic ms_hit_b;
    logic ws_hit_a;
    logic ws_hit_b;

    // r0 is never a real dependency
    function automatic logic hit(logic valid, logic gr_we, reg_idx_t dest, reg_idx_t src);
        hit = valid && gr_we && (dest != '0) && (dest == src);
    endfunction

    assign es_hit_a = hit(es_valid, es_gr_we, es_dest, ds_rs);
    assign es_hit_b = hit(es_valid, es_gr_we, es_dest, ds_rt);
    assign ms_hit_a = hit(ms_valid, ms_gr_we, ms_dest, ds_rs);
    assign ms_hit_b = hit(ms_valid, ms_gr_we, ms_dest, ds_rt);
    assign ws_hit_a = hit(ws_valid, ws_gr_we, ws_dest, ds_rs);
    assign ws_hit_b = hit(ws_valid, ws_gr_we, ws_dest, ds_rt);

    // youngest writer first
    assign fwd_a = es_hit_a ? FWD_EX : ms_hit_a ? FWD_MEM : ws_hit_a ? FWD_WB : FWD_NONE;
    assign fwd_b = es_hit_b ? FWD_EX : ms_hit_b ? FWD_MEM : ws_hit_b ? FWD_WB : FWD_NONE;

    // load data is not back until memory, hold one cycle
    assign load_stall = es_load && (es_hit_a || es_hit_b);

endmodule

/* logic/mem_stage.sv */
module mem_stage
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     es_to_ms_valid,
    input  word_t    es_pc,
    input  word_t    es_result,
    input  reg_idx_t es_dest,
    input  logic     es_gr_we,
    input  logic     es_load,
    output logic     ms_allowin,
    input  logic     ws_allowin,
    output logic     ms_to_ws_valid,
    output word_t    ms_pc,
    output word_t    ms_result,
    output reg_idx_t ms_dest,
    output logic     ms_gr_we,
    input  word_t    data_sram_rdata
);

    logic  ms_valid;
    logic  ms_load;
    word_t alu_result;

    assign ms_allowin     = !ms_valid || ws_allowin;
    assign ms_to_ws_valid = ms_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= es_to_ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms_allowin && es_to_ms_valid) begin
            ms_pc      <= es_pc;
            alu_result <= es_result;
            ms_dest    <= es_dest;
            ms_gr_we   <= es_gr_we;
            ms_load    <= es_load;
        end
    end

    // load data returns this cycle, one after the request
    assign ms_result = ms_load ? data_sram_rdata : alu_result;

endmodule

/* logic/reg_file.sv */
`include "cpu_cfg.svh"

module reg_file
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t raddr1,
    input  reg_idx_t raddr2,
    output word_t    rdata1,
    output word_t    rdata2,
    input  logic     we,
    input  reg_idx_t waddr,
    input  word_t    wdata
);

    word_t regs [`CPU_NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 reads zero, a write in the same cycle passes straight through
    assign rdata1 = (raddr1 == '0) ? '0 :
                    (we && waddr == raddr1) ? wdata : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 :
                    (we && waddr == raddr2) ? wdata : regs[raddr2];

endmodule

/* logic/wb_stage.sv */
module wb_stage
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     ms_to_ws_valid,
    input  word_t    ms_pc,
    input  word_t    ms_result,
    input  reg_idx_t ms_dest,
    input  logic     ms_gr_we,
    output logic     ws_allowin,
    output logic     rf_we,
    output reg_idx_t rf_waddr,
    output word_t    rf_wdata,
    output word_t    debug_wb_pc,
    output byte_en_t debug_wb_rf_wen,
    output reg_idx_t debug_wb_rf_wnum,
    output word_t    debug_wb_rf_wdata
);

    logic ws_valid;
    logic ws_gr_we;

    // retires every cycle, so never full
    assign ws_allowin = 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ws_valid <= 1'b0;
        end else begin
            ws_valid <= ms_to_ws_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms_to_ws_valid) begin
            debug_wb_pc <= ms_pc;
            rf_wdata    <= ms_result;
            rf_waddr    <= ms_dest;
            ws_gr_we    <= ms_gr_we;
        end
    end

    assign rf_we = ws_valid && ws_gr_we;

    // trace follows the register write
    assign debug_wb_rf_wen   = rf_we ? '1 : '0;
    assign debug_wb_rf_wnum  = rf_waddr;
    assign debug_wb_rf_wdata = rf_wdata;

endmodule

/* sim.f */
+incdir+logic
logic/cpu_pkg.sv
logic/fetch_stage.sv
logic/reg_file.sv
logic/decode_stage.sv
logic/exec_stage.sv
logic/mem_stage.sv
logic/wb_stage.sv
logic/hazard_unit.sv
logic/cpu_top.sv
dv/cpu_props.sv
dv/cpu_tb.sv
